//--- hdl/cheat_pkg.sv
package cheat_pkg;

  // six slots, fixed by the 3-bit programming index map
  localparam int NUM_SLOTS = 6;

  // vector fetch addresses in bank 00
  localparam logic [23:0] VEC_NMI_LO = 24'h00ffea;
  localparam logic [23:0] VEC_NMI_HI = 24'h00ffeb;
  localparam logic [23:0] VEC_IRQ_LO = 24'h00ffee;
  localparam logic [23:0] VEC_IRQ_HI = 24'h00ffef;
  localparam logic [23:0] VEC_RST_LO = 24'h00fffc;
  localparam logic [23:0] VEC_RST_HI = 24'h00fffd;

  // substituted bytes
  localparam logic [7:0] HOOK_BANK_BYTE     = 8'h10;
  localparam logic [7:0] RST_HOOK_BYTE      = 8'h7d;
  localparam logic [7:0] IDLE_BYTE          = 8'h2a;
  localparam logic [7:0] RETURN_VECTOR_INIT = 8'hea;
  localparam logic [7:0] BRANCH3_OFFSET     = 8'h04;

  // PB, PCH, PCL and P go onto the stack before the vector fetch
  localparam logic [2:0] PUSH_COUNT_HOOK = 3'd4;

  // offsets inside the command area
  localparam logic [8:0] CMD_OFS    = 9'h000;
  localparam logic [8:0] PAD_LO_OFS = 9'h1f0;
  localparam logic [8:0] PAD_HI_OFS = 9'h1f1;
  localparam logic [8:0] EXIT_OFS   = 9'h1fd;

  typedef enum logic [7:0] {
    CMD_CHEAT_ON  = 8'h82,
    CMD_CHEAT_OFF = 8'h83,
    CMD_HOOKS_OFF = 8'h84,
    CMD_HOLDOFF   = 8'h85
  } snescmd_op_e;

  typedef enum logic [1:0] {
    PGM_SLOT,
    PGM_MASK,
    PGM_FLAGS
  } pgm_op_e;

  // button words that select pad commands 80 to 85
  typedef enum logic [15:0] {
    PAD_LR_START_SELECT = 16'h3030,
    PAD_LR_SELECT_X     = 16'h2070,
    PAD_LR_START_A      = 16'h10b0,
    PAD_LR_START_B      = 16'h9030,
    PAD_LR_START_Y      = 16'h5030,
    PAD_LR_START_X      = 16'h1070
  } pad_cmd_e;

  function automatic pgm_op_e pgm_op(input logic [2:0] idx);
    if (idx < NUM_SLOTS) return PGM_SLOT;
    else if (idx == NUM_SLOTS) return PGM_MASK;
    else return PGM_FLAGS;
  endfunction

endpackage

//--- hdl/snes_bus_if.sv
interface snes_bus_if;

  logic [23:0] addr;
  logic [7:0]  pa;
  logic [7:0]  data;
  logic        wr_strobe;
  logic        rd_strobe;
  logic        cycle_start;

  // vector address matches
  logic        nmi_lo;
  logic        nmi_hi;
  logic        irq_lo;
  logic        irq_hi;
  logic        rst_lo;
  logic        rst_hi;

  // four descending stack pushes seen
  logic        push_armed;

  modport decoder (
    output addr, pa, data, wr_strobe, rd_strobe, cycle_start,
    output nmi_lo, nmi_hi, irq_lo, irq_hi, rst_lo, rst_hi, push_armed
  );

  modport sink (
    input addr, pa, data, wr_strobe, rd_strobe, cycle_start,
    input nmi_lo, nmi_hi, irq_lo, irq_hi, rst_lo, rst_hi, push_armed
  );

endinterface

//--- hdl/ctrl_if.sv
interface ctrl_if;

  // global flags
  logic       cheat_enable;
  logic       nmi_enable;
  logic       irq_enable;
  logic       holdoff_enable;
  logic       buttons_enable;
  logic       wram_present;

  // bytes served to the hook code
  logic [7:0] nmicmd;
  logic [7:0] branch1_offset;
  logic [7:0] branch2_offset;

  logic       exit_strobe;
  logic       holdoff_strobe;

  modport source (
    output cheat_enable, nmi_enable, irq_enable, holdoff_enable, buttons_enable,
    output wram_present, nmicmd, branch1_offset, branch2_offset,
    output exit_strobe, holdoff_strobe
  );

  modport sink (
    input cheat_enable, nmi_enable, irq_enable, holdoff_enable, buttons_enable,
    input wram_present, nmicmd, branch1_offset, branch2_offset,
    input exit_strobe, holdoff_strobe
  );

endinterface

//--- hdl/vector_decode.sv
module vector_decode (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  logic [23:0] addr,
  input  logic [7:0]  pa,
  input  logic [7:0]  data,
  input  logic        wr_strobe,
  input  logic        rd_strobe,
  input  logic        cycle_start,
  snes_bus_if.decoder bus
);

  logic [2:0] push_cnt;
  logic [7:0] next_pa;

  assign bus.addr        = addr;
  assign bus.pa          = pa;
  assign bus.data        = data;
  assign bus.wr_strobe   = wr_strobe;
  assign bus.rd_strobe   = rd_strobe;
  assign bus.cycle_start = cycle_start;

  assign bus.nmi_lo = (addr == cheat_pkg::VEC_NMI_LO);
  assign bus.nmi_hi = (addr == cheat_pkg::VEC_NMI_HI);
  assign bus.irq_lo = (addr == cheat_pkg::VEC_IRQ_LO);
  assign bus.irq_hi = (addr == cheat_pkg::VEC_IRQ_HI);
  assign bus.rst_lo = (addr == cheat_pkg::VEC_RST_LO);
  assign bus.rst_hi = (addr == cheat_pkg::VEC_RST_HI);

  assign bus.push_armed = (push_cnt == cheat_pkg::PUSH_COUNT_HOOK);

  // interrupt entry pushes through the B bus mirror with descending
  // stack addresses, which a backwards DMA on the A bus cannot mimic
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      push_cnt <= '0;
    end else if (wr_strobe) begin
      push_cnt <= push_cnt + 3'd1;
      if (push_cnt == 3'd0) begin
        next_pa <= pa - 8'd1;
      end else if (pa == next_pa) begin
        next_pa <= next_pa - 8'd1;
      end else begin
        push_cnt <= '0;
      end
    end else if (rd_strobe) begin
      push_cnt <= '0;
    end
  end

  // a bus cycle is a read or a write, never both
  a_strobe_excl: assert property (@(posedge clk) !(wr_strobe && rd_strobe));

endmodule

//--- hdl/patch_table.sv
module patch_table (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  logic [2:0]  pgm_idx,
  input  logic        pgm_we,
  input  logic [31:0] pgm_in,
  snes_bus_if.sink    bus,
  output logic        hit,
  output logic [7:0]  data
);

  logic [23:0] slot_addr [cheat_pkg::NUM_SLOTS];
  logic [7:0]  slot_data [cheat_pkg::NUM_SLOTS];
  logic [cheat_pkg::NUM_SLOTS-1:0] slot_mask = '0;
  logic [cheat_pkg::NUM_SLOTS-1:0] match;

  // programming port, ignored while the console sits in reset
  always_ff @(posedge clk) begin
    if (pgm_we && !SNES_reset_strobe) begin
      case (cheat_pkg::pgm_op(pgm_idx))
        cheat_pkg::PGM_SLOT: begin
          slot_addr[pgm_idx] <= pgm_in[31:8];
          slot_data[pgm_idx] <= pgm_in[7:0];
        end
        cheat_pkg::PGM_MASK: begin
          slot_mask <= pgm_in[cheat_pkg::NUM_SLOTS-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < cheat_pkg::NUM_SLOTS; i++) begin
      match[i] = slot_mask[i] && (bus.addr == slot_addr[i]);
    end
  end

  assign hit = |match;

  // lowest slot wins, so scan downwards and let it overwrite
  always_comb begin
    data = '0;
    for (int i = cheat_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
      if (match[i]) begin
        data = slot_data[i];
      end
    end
  end

endmodule

//--- hdl/snescmd_decode.sv
module snescmd_decode (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  logic        snescmd_enable,
  input  logic        snescmd_unlock,
  input  logic        pad_latch,
  input  logic        snes_ajr,
  input  logic [2:0]  pgm_idx,
  input  logic        pgm_we,
  input  logic [31:0] pgm_in,
  snes_bus_if.sink    bus,
  ctrl_if.source      ctrl
);

  logic        cmd_wr;
  logic        cmd_unlocked;
  logic [8:0]  ofs;
  logic        branch_wram;
  // {wram, buttons, holdoff, irq, nmi, cheat}
  logic [5:0]  flags = '0;
  logic [15:0] pad_data = '0;

  assign cmd_wr       = snescmd_enable && bus.wr_strobe;
  assign cmd_unlocked = cmd_wr && snescmd_unlock;
  assign ofs          = bus.addr[8:0];

  assign ctrl.cheat_enable   = flags[0];
  assign ctrl.nmi_enable     = flags[1];
  assign ctrl.irq_enable     = flags[2];
  assign ctrl.holdoff_enable = flags[3];
  assign ctrl.buttons_enable = flags[4];
  assign ctrl.wram_present   = flags[5];

  assign ctrl.holdoff_strobe = cmd_unlocked && (ofs == cheat_pkg::CMD_OFS)
                               && (bus.data == cheat_pkg::CMD_HOLDOFF);

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      ctrl.exit_strobe <= 1'b0;
    end else begin
      ctrl.exit_strobe <= cmd_unlocked && (ofs == cheat_pkg::EXIT_OFS);
      if (cmd_unlocked) begin
        if (ofs == cheat_pkg::CMD_OFS) begin
          case (bus.data)
            cheat_pkg::CMD_CHEAT_ON:  flags[0] <= 1'b1;
            cheat_pkg::CMD_CHEAT_OFF: flags[0] <= 1'b0;
            cheat_pkg::CMD_HOOKS_OFF: flags[2:1] <= 2'b00;
            default: begin
            end
          endcase
        end
      end else if (pgm_we && cheat_pkg::pgm_op(pgm_idx) == cheat_pkg::PGM_FLAGS) begin
        // bits 13:8 clear, bits 5:0 set
        flags <= (flags & ~pgm_in[13:8]) | pgm_in[5:0];
      end
    end
  end

  // joypad word mirrored by the hook code
  always_ff @(posedge clk) begin
    if (cmd_wr && ofs == cheat_pkg::PAD_LO_OFS) pad_data[7:0] <= bus.data;
    if (cmd_wr && ofs == cheat_pkg::PAD_HI_OFS) pad_data[15:8] <= bus.data;
  end

  always_comb begin
    case (pad_data)
      cheat_pkg::PAD_LR_START_SELECT: ctrl.nmicmd = 8'h80;
      cheat_pkg::PAD_LR_SELECT_X:     ctrl.nmicmd = 8'h81;
      cheat_pkg::PAD_LR_START_A:      ctrl.nmicmd = 8'h82;
      cheat_pkg::PAD_LR_START_B:      ctrl.nmicmd = 8'h83;
      cheat_pkg::PAD_LR_START_Y:      ctrl.nmicmd = 8'h84;
      cheat_pkg::PAD_LR_START_X:      ctrl.nmicmd = 8'h85;
      default:                        ctrl.nmicmd = 8'h00;
    endcase
  end

  assign branch_wram = flags[0] && flags[5];

  always_comb begin
    if (flags[4] && !snes_ajr && !pad_latch) begin
      ctrl.branch1_offset = 8'h00;  // back to the main loop
    end else if (flags[4] && snes_ajr && ctrl.nmicmd != 8'h00) begin
      ctrl.branch1_offset = 8'h30;  // echo the command
    end else begin
      ctrl.branch1_offset = branch_wram ? 8'h3a : 8'h43;
    end
  end

  always_comb begin
    if (ctrl.nmicmd == 8'h81) ctrl.branch2_offset = 8'h14;
    else ctrl.branch2_offset = branch_wram ? 8'h00 : 8'h09;
  end

  a_exit_pulse: assert property (@(posedge clk) disable iff (SNES_reset_strobe)
    ctrl.exit_strobe |=> !ctrl.exit_strobe);

endmodule

//--- hdl/hook_control.sv
module hook_control #(
  parameter int HOLDOFF_CYCLES = 960000000,
  parameter int USAGE_PERIOD   = 2097152,
  parameter int EXIT_CYCLES    = 72
) (
  input  logic       clk,
  input  logic       SNES_reset_strobe,
  snes_bus_if.sink   bus,
  ctrl_if.sink       ctrl,
  output logic       snescmd_unlock,
  output logic       hook_active,
  output logic       vector_unlock,
  output logic       reset_unlock,
  output logic [7:0] return_vector
);

  localparam int HOLD_W = $clog2(HOLDOFF_CYCLES + 1);
  localparam int USE_W  = $clog2(USAGE_PERIOD);
  localparam int EXIT_W = $clog2(EXIT_CYCLES + 1);

  logic              arm;
  logic              vec_win;
  logic [1:0]        reset_cnt;
  logic              exiting;
  logic [EXIT_W-1:0] exit_cnt;
  logic [HOLD_W-1:0] hold_cnt;
  logic [USE_W-1:0]  use_cnt;
  logic [4:0]        nmi_use;
  logic [4:0]        irq_use;
  logic              auto_nmi;
  logic              nmi_sync;
  logic              irq_sync;
  logic [1:0]        sync_delay;
  logic [7:0]        ret_vec = cheat_pkg::RETURN_VECTOR_INIT;

  ////////////////////////////////////////////////////////////////////////////
  // vector and reset windows

  // armed while the high vector byte is fetched right after the pushes
  assign arm = hook_active && bus.push_armed
               && ((nmi_sync && ctrl.nmi_enable && bus.nmi_hi)
                || (irq_sync && ctrl.irq_enable && bus.irq_hi));

  assign vector_unlock = arm || vec_win;
  assign reset_unlock  = |reset_cnt;
  assign return_vector = ret_vec;

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      vec_win   <= 1'b0;
      reset_cnt <= 2'd3;
    end else begin
      if (bus.rd_strobe) vec_win <= arm;
      // three fetches allowed, covers the masked read of some loaders
      if (bus.cycle_start && (bus.rst_lo || bus.rst_hi) && reset_unlock) begin
        reset_cnt <= reset_cnt - 2'd1;
      end
    end
  end

  // remember which vector was taken for the hook exit
  always_ff @(posedge clk) begin
    if (bus.rd_strobe && arm) ret_vec <= bus.addr[7:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // command area unlock and exit countdown

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      snescmd_unlock <= 1'b0;
      exiting        <= 1'b0;
      exit_cnt       <= '0;
    end else begin
      if (bus.rd_strobe && (arm || (bus.rst_hi && reset_unlock))) begin
        snescmd_unlock <= 1'b1;
      end
      // leave the hook code time to jump back to the real vector
      if (bus.cycle_start && exiting) begin
        if (exit_cnt != '0) begin
          exit_cnt <= exit_cnt - 1'b1;
        end else begin
          snescmd_unlock <= 1'b0;
          exiting        <= 1'b0;
        end
      end
      if (ctrl.exit_strobe) begin
        exit_cnt <= EXIT_W'(EXIT_CYCLES);
        exiting  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // holdoff, autoselect and sync

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      hold_cnt <= ctrl.holdoff_enable ? HOLD_W'(HOLDOFF_CYCLES) : '0;
    end else if (ctrl.holdoff_strobe) begin
      hold_cnt <= HOLD_W'(HOLDOFF_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // nmi wins when both are used or irq is never fetched
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      use_cnt  <= USE_W'(USAGE_PERIOD - 1);
      nmi_use  <= '0;
      irq_use  <= '0;
      auto_nmi <= 1'b1;
    end else if (use_cnt == '0) begin
      use_cnt  <= USE_W'(USAGE_PERIOD - 1);
      nmi_use  <= '0;
      irq_use  <= '0;
      auto_nmi <= (nmi_use != '0) || (irq_use == '0);
    end else begin
      use_cnt <= use_cnt - 1'b1;
      if (bus.cycle_start && bus.nmi_hi && !(&nmi_use)) nmi_use <= nmi_use + 5'd1;
      if (bus.cycle_start && bus.irq_hi && !(&irq_use)) irq_use <= irq_use + 5'd1;
    end
  end

  // never switch the vectors in the middle of a fetch
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      sync_delay  <= 2'd2;
      nmi_sync    <= 1'b0;
      irq_sync    <= 1'b0;
      hook_active <= 1'b0;
    end else if (bus.cycle_start) begin
      if (bus.nmi_lo || bus.nmi_hi || bus.irq_lo || bus.irq_hi) begin
        sync_delay <= 2'd2;
      end else if (sync_delay != 2'd0) begin
        sync_delay <= sync_delay - 2'd1;
      end else begin
        nmi_sync    <= auto_nmi;
        irq_sync    <= !auto_nmi;
        hook_active <= (hold_cnt == '0);
      end
    end
  end

endmodule

//--- hdl/patch_response.sv
module patch_response (
  snes_bus_if.sink   bus,
  ctrl_if.sink       ctrl,
  input  logic       hit,
  input  logic [7:0] data,
  input  logic       snescmd_unlock,
  input  logic       hook_active,
  input  logic       vector_unlock,
  input  logic       reset_unlock,
  input  logic [7:0] return_vector,
  input  logic       nmicmd_enable,
  input  logic       return_vector_enable,
  input  logic       branch1_enable,
  input  logic       branch2_enable,
  input  logic       branch3_enable,
  output logic [7:0] data_out,
  output logic       cheat_hit
);

  logic hook_read;
  logic vec_read;

  always_comb begin
    if (hit) data_out = data;
    else if (bus.nmi_hi || bus.irq_hi) data_out = cheat_pkg::HOOK_BANK_BYTE;
    else if (bus.rst_hi) data_out = cheat_pkg::RST_HOOK_BYTE;
    else if (nmicmd_enable) data_out = ctrl.nmicmd;
    else if (return_vector_enable) data_out = return_vector;
    else if (branch1_enable) data_out = ctrl.branch1_offset;
    else if (branch2_enable) data_out = ctrl.branch2_offset;
    else if (branch3_enable) data_out = cheat_pkg::BRANCH3_OFFSET;
    else data_out = cheat_pkg::IDLE_BYTE;
  end

  // reads of the hook's own data bytes
  assign hook_read = nmicmd_enable || return_vector_enable
                     || branch1_enable || branch2_enable || branch3_enable;

  assign vec_read = (ctrl.nmi_enable && (bus.nmi_lo || bus.nmi_hi))
                    || (ctrl.irq_enable && (bus.irq_lo || bus.irq_hi));

  assign cheat_hit = (snescmd_unlock && hook_active && hook_read)
                     || (reset_unlock && (bus.rst_lo || bus.rst_hi))
                     || (ctrl.cheat_enable && hit)
                     || (hook_active && vector_unlock && vec_read);

endmodule

//--- hdl/cheat_top.sv
module cheat_top #(
  parameter int HOLDOFF_CYCLES = 960000000,
  parameter int USAGE_PERIOD   = 2097152,
  parameter int EXIT_CYCLES    = 72
) (
  input  logic        clk,
  input  logic [7:0]  SNES_PA,
  input  logic [23:0] SNES_ADDR,
  input  logic [7:0]  SNES_DATA,
  input  logic        SNES_wr_strobe,
  input  logic        SNES_rd_strobe,
  input  logic        SNES_reset_strobe,
  input  logic        snescmd_enable,
  input  logic        nmicmd_enable,
  input  logic        return_vector_enable,
  input  logic        branch1_enable,
  input  logic        branch2_enable,
  input  logic        branch3_enable,
  input  logic        pad_latch,
  input  logic        snes_ajr,
  input  logic        SNES_cycle_start,
  input  logic [2:0]  pgm_idx,
  input  logic        pgm_we,
  input  logic [31:0] pgm_in,
  output logic [7:0]  data_out,
  output logic        cheat_hit,
  output logic        snescmd_unlock
);

  logic       patch_hit;
  logic [7:0] patch_data;
  logic       hook_active;
  logic       vector_unlock;
  logic       reset_unlock;
  logic [7:0] return_vector;

  snes_bus_if bus ();
  ctrl_if     ctrl ();

  vector_decode vector_decode_i (
    .clk, .SNES_reset_strobe,
    .addr(SNES_ADDR), .pa(SNES_PA), .data(SNES_DATA),
    .wr_strobe(SNES_wr_strobe), .rd_strobe(SNES_rd_strobe),
    .cycle_start(SNES_cycle_start), .bus(bus.decoder)
  );

  patch_table patch_table_i (
    .clk, .SNES_reset_strobe, .pgm_idx, .pgm_we, .pgm_in,
    .bus(bus.sink), .hit(patch_hit), .data(patch_data)
  );

  snescmd_decode snescmd_decode_i (
    .clk, .SNES_reset_strobe, .snescmd_enable, .snescmd_unlock,
    .pad_latch, .snes_ajr, .pgm_idx, .pgm_we, .pgm_in,
    .bus(bus.sink), .ctrl(ctrl.source)
  );

  hook_control #(
    .HOLDOFF_CYCLES(HOLDOFF_CYCLES),
    .USAGE_PERIOD(USAGE_PERIOD),
    .EXIT_CYCLES(EXIT_CYCLES)
  ) hook_control_i (
    .clk, .SNES_reset_strobe, .bus(bus.sink), .ctrl(ctrl.sink),
    .snescmd_unlock, .hook_active, .vector_unlock, .reset_unlock, .return_vector
  );

  patch_response patch_response_i (
    .bus(bus.sink), .ctrl(ctrl.sink), .hit(patch_hit), .data(patch_data),
    .snescmd_unlock, .hook_active, .vector_unlock, .reset_unlock, .return_vector,
    .nmicmd_enable, .return_vector_enable,
    .branch1_enable, .branch2_enable, .branch3_enable,
    .data_out, .cheat_hit
  );

endmodule

//--- verification/cheat_tests.svh
`ifndef CHEAT_TESTS_SVH
`define CHEAT_TESTS_SVH

// three fetches of the reset vector are served, the byte stays after that
task automatic reset_window_test();
  logic [7:0] d;
  logic       h;
  for (int i = 0; i < 4; i++) begin
    bus_read(RST_HI_ADDR, d, h);
    expect_equal(d, 8'h7d, $sformatf("reset vector byte, fetch %0d", i));
    expect_equal(h, i < 3, $sformatf("reset window hit, fetch %0d", i));
  end
endtask

// slots 0, 2, 3 and 5 enabled, a distinct bank per slot
task automatic patch_slots_test();
  logic [7:0] d;
  logic       h;
  for (int i = 0; i < 6; i++) begin
    slot_addr[i] = {8'h40 + 8'(i), 16'($urandom)};
    slot_byte[i] = 8'($urandom);
    pgm_write(3'(i), {slot_addr[i], slot_byte[i]});
  end
  pgm_write(3'd6, 32'h0000_002d);
  pgm_write(3'd7, 32'h0000_0001);
  for (int i = 0; i < 6; i++) begin
    bus_read(slot_addr[i], d, h);
    if (i == 1 || i == 4) begin
      expect_equal(d, 8'h2a, $sformatf("masked slot %0d byte", i));
      expect_equal(h, 1'b0, $sformatf("masked slot %0d hit", i));
    end else begin
      expect_equal(d, slot_byte[i], $sformatf("slot %0d byte", i));
      expect_equal(h, 1'b1, $sformatf("slot %0d hit", i));
    end
  end
  bus_read({8'h3f, 16'($urandom)}, d, h);
  expect_equal(d, 8'h2a, "unmatched address byte");
  expect_equal(h, 1'b0, "unmatched address hit");
  // slot 5 moved onto slot 2, the lower slot has to win
  slot_addr[5] = slot_addr[2];
  slot_byte[5] = slot_byte[2] ^ 8'h5a;
  pgm_write(3'd5, {slot_addr[5], slot_byte[5]});
  bus_read(slot_addr[2], d, h);
  expect_equal(d, slot_byte[2], "shared address byte");
  expect_equal(h, 1'b1, "shared address hit");
endtask

task automatic nmi_hook_test();
  logic [7:0] d;
  logic       h;
  apply_reset();
  pgm_write(3'd7, 32'h0000_0002);
  idle_cycles(3);
  nmi_entry(1'b0, d, h);
  expect_equal(d, 8'h10, "broken push vector byte");
  expect_equal(h, 1'b0, "broken push hit");
  expect_equal(snescmd_unlock, 1'b0, "broken push unlock");
  nmi_entry(1'b1, d, h);
  expect_equal(d, 8'h10, "nmi hook vector byte");
  expect_equal(h, 1'b1, "nmi hook hit");
  expect_equal(snescmd_unlock, 1'b1, "nmi hook unlock");
  hook_read(SEL_RETVEC, d, h);
  expect_equal(d, 8'heb, "return vector");
  expect_equal(h, 1'b1, "return vector hit");
endtask

task automatic command_test();
  logic [7:0] d;
  logic       h;
  expect_equal(snescmd_unlock, 1'b1, "unlock before commands");
  cmd_write(9'h000, 8'h83);
  bus_read(slot_addr[0], d, h);
  expect_equal(d, slot_byte[0], "slot byte with cheats off");
  expect_equal(h, 1'b0, "slot hit with cheats off");
  cmd_write(9'h000, 8'h82);
  bus_read(slot_addr[0], d, h);
  expect_equal(h, 1'b1, "slot hit with cheats on");
  // pad word goes low byte first
  cmd_write(9'h1f0, 8'h30);
  cmd_write(9'h1f1, 8'h30);
  hook_read(SEL_NMICMD, d, h);
  expect_equal(d, 8'h80, "pad 3030 command");
  cmd_write(9'h1f0, 8'hb0);
  cmd_write(9'h1f1, 8'h10);
  hook_read(SEL_NMICMD, d, h);
  expect_equal(d, 8'h82, "pad 10b0 command");
  cmd_write(9'h1f0, 8'h34);
  cmd_write(9'h1f1, 8'h12);
  hook_read(SEL_NMICMD, d, h);
  expect_equal(d, 8'h00, "unknown pad word");
  hook_read(SEL_BRANCH1, d, h);
  expect_equal(d, 8'h43, "branch1 without wram");
  pgm_write(3'd7, 32'h0000_0020);
  hook_read(SEL_BRANCH1, d, h);
  expect_equal(d, 8'h3a, "branch1 with wram and cheats");
endtask

task automatic exit_countdown_test();
  cmd_write(9'h1fd, 8'h00);
  for (int i = 0; i < EXIT_CYCLES; i++) begin
    idle_cycles(1);
    expect_equal(snescmd_unlock, 1'b1, $sformatf("unlock during exit, cycle %0d", i));
  end
  idle_cycles(1);
  expect_equal(snescmd_unlock, 1'b0, "unlock after exit countdown");
endtask

task automatic holdoff_test();
  logic [7:0] d;
  logic       h;
  nmi_entry(1'b1, d, h);
  expect_equal(h, 1'b1, "hook live before holdoff");
  cmd_write(9'h000, 8'h85);
  exit_countdown_test();
  nmi_entry(1'b1, d, h);
  expect_equal(d, 8'h10, "vector byte during holdoff");
  expect_equal(h, 1'b0, "hit during holdoff");
  expect_equal(snescmd_unlock, 1'b0, "unlock during holdoff");
  // timer runs on clk, then the sync delay
  repeat (HOLDOFF_CYCLES) @(posedge clk);
  idle_cycles(3);
  nmi_entry(1'b1, d, h);
  expect_equal(h, 1'b1, "hit after holdoff");
  expect_equal(snescmd_unlock, 1'b1, "unlock after holdoff");
endtask

`endif

//--- verification/cheat_tb.sv
module cheat_tb;

  localparam int HOLDOFF_CYCLES = 400;
  localparam int USAGE_PERIOD   = 4096;
  localparam int EXIT_CYCLES    = 4;
  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 16;

  // two resets, the holdoff wait and about a hundred bus operations,
  // doubled for margin
  localparam int BUS_OPS         = 100;
  localparam int WATCHDOG_CYCLES = 2 * (2 * RESET_CYCLES + HOLDOFF_CYCLES + 4 * BUS_OPS);

  localparam logic [23:0] NMI_HI_ADDR = 24'h00ffeb;
  localparam logic [23:0] RST_HI_ADDR = 24'h00fffd;
  localparam logic [23:0] CMD_BASE    = 24'h002a00;
  localparam logic [23:0] IDLE_ADDR   = 24'h002a20;
  localparam logic [23:0] STACK_BASE  = 24'h001f00;

  // hook byte selects for hook_read
  localparam int SEL_NMICMD  = 0;
  localparam int SEL_RETVEC  = 1;
  localparam int SEL_BRANCH1 = 2;

  logic        clk = 1'b0;
  logic [7:0]  SNES_PA;
  logic [23:0] SNES_ADDR;
  logic [7:0]  SNES_DATA;
  logic        SNES_wr_strobe;
  logic        SNES_rd_strobe;
  logic        SNES_reset_strobe;
  logic        snescmd_enable;
  logic        nmicmd_enable;
  logic        return_vector_enable;
  logic        branch1_enable;
  logic        branch2_enable;
  logic        branch3_enable;
  logic        pad_latch;
  logic        snes_ajr;
  logic        SNES_cycle_start;
  logic [2:0]  pgm_idx;
  logic        pgm_we;
  logic [31:0] pgm_in;
  logic [7:0]  data_out;
  logic        cheat_hit;
  logic        snescmd_unlock;

  // what the patch test programmed
  logic [23:0] slot_addr [6];
  logic [7:0]  slot_byte [6];
  int          errors = 0;

  cheat_top #(
    .HOLDOFF_CYCLES(HOLDOFF_CYCLES),
    .USAGE_PERIOD(USAGE_PERIOD),
    .EXIT_CYCLES(EXIT_CYCLES)
  ) cheat_top_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // checking and bus tasks

  task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    SNES_reset_strobe <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    SNES_reset_strobe <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pgm_write(input logic [2:0] idx, input logic [31:0] value);
    @(posedge clk);
    pgm_idx <= idx;
    pgm_in  <= value;
    pgm_we  <= 1'b1;
    @(posedge clk);
    pgm_we  <= 1'b0;
  endtask

  // data_out and cheat_hit are taken in the cycle_start cycle
  task automatic bus_read(input logic [23:0] addr, output logic [7:0] d, output logic h);
    @(posedge clk);
    SNES_ADDR        <= addr;
    SNES_cycle_start <= 1'b1;
    @(negedge clk);
    d = data_out;
    h = cheat_hit;
    @(posedge clk);
    SNES_cycle_start <= 1'b0;
    SNES_rd_strobe   <= 1'b1;
    @(posedge clk);
    SNES_rd_strobe   <= 1'b0;
    @(negedge clk);
  endtask

  task automatic bus_write(input logic [23:0] addr, input logic [7:0] pa,
                           input logic [7:0] wdata);
    @(posedge clk);
    SNES_ADDR        <= addr;
    SNES_PA          <= pa;
    SNES_DATA        <= wdata;
    SNES_cycle_start <= 1'b1;
    @(posedge clk);
    SNES_cycle_start <= 1'b0;
    SNES_wr_strobe   <= 1'b1;
    @(posedge clk);
    SNES_wr_strobe   <= 1'b0;
    @(negedge clk);
  endtask

  task automatic cmd_write(input logic [8:0] ofs, input logic [7:0] wdata);
    @(posedge clk);
    snescmd_enable <= 1'b1;
    bus_write(CMD_BASE | 24'(ofs), 8'h00, wdata);
    @(posedge clk);
    snescmd_enable <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    logic [7:0] d;
    logic       h;
    repeat (n) bus_read(IDLE_ADDR, d, h);
  endtask

  task automatic hook_read(input int sel, output logic [7:0] d, output logic h);
    @(posedge clk);
    nmicmd_enable        <= (sel == SEL_NMICMD);
    return_vector_enable <= (sel == SEL_RETVEC);
    branch1_enable       <= (sel == SEL_BRANCH1);
    bus_read(IDLE_ADDR, d, h);
    @(posedge clk);
    nmicmd_enable        <= 1'b0;
    return_vector_enable <= 1'b0;
    branch1_enable       <= 1'b0;
  endtask

  // four stack pushes then the high NMI vector fetch
  task automatic nmi_entry(input logic intact, output logic [7:0] d, output logic h);
    logic [7:0] pa;
    pa = 8'h50;
    for (int i = 0; i < 4; i++) begin
      if (!intact && i == 2) pa = 8'h40;
      bus_write(STACK_BASE | 24'(pa), pa, 8'h00);
      pa = pa - 8'd1;
    end
    bus_read(NMI_HI_ADDR, d, h);
  endtask

  `include "cheat_tests.svh"

  ////////////////////////////////////////////////////////////////////////////
  // sequence and watchdog

  initial begin
    SNES_PA = '0;
    SNES_ADDR = '0;
    SNES_DATA = '0;
    SNES_wr_strobe = 1'b0;
    SNES_rd_strobe = 1'b0;
    SNES_reset_strobe = 1'b1;
    SNES_cycle_start = 1'b0;
    snescmd_enable = 1'b0;
    nmicmd_enable = 1'b0;
    return_vector_enable = 1'b0;
    branch1_enable = 1'b0;
    branch2_enable = 1'b0;
    branch3_enable = 1'b0;
    pad_latch = 1'b0;
    snes_ajr = 1'b0;
    pgm_idx = '0;
    pgm_we = 1'b0;
    pgm_in = '0;
    void'($urandom(94990));
    apply_reset();
    reset_window_test();
    patch_slots_test();
    nmi_hook_test();
    command_test();
    exit_countdown_test();
    holdoff_test();
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Errors found");
    $fatal(1, "timeout");
  end

endmodule

//--- src.f
+incdir+verification
hdl/cheat_pkg.sv
hdl/snes_bus_if.sv
hdl/ctrl_if.sv
hdl/vector_decode.sv
hdl/patch_table.sv
hdl/snescmd_decode.sv
hdl/hook_control.sv
hdl/patch_response.sv
hdl/cheat_top.sv
verification/cheat_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := cheat_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
